// ==== hdl/video_capture_pkg.sv ====
package video_capture_pkg;

    // Default raster, 800x600 at 60 Hz SVGA timing
    localparam int def_x_res   = 800;
    localparam int def_y_res   = 600;
    localparam int def_h_front = 40;
    localparam int def_h_sync  = 128;
    localparam int def_h_back  = 88;
    localparam int def_v_front = 1;
    localparam int def_v_sync  = 4;
    localparam int def_v_back  = 23;

    localparam int def_history = 5;     // Sync filter run length
    localparam int def_fifo_depth = 1024;

    // APB register map, byte addresses
    localparam logic [11:0] reg_ctrl   = 12'h000;
    localparam logic [11:0] reg_status = 12'h004;
    localparam logic [11:0] reg_pixel  = 12'h008;
    localparam logic [11:0] reg_frames = 12'h00C;

    typedef logic [10:0] coord_t;

    typedef struct packed {
        logic [4:0] red;
        logic [5:0] green;
        logic [4:0] blue;
    } rgb565_t;

    // One captured pixel with its framing tags
    typedef struct packed {
        logic    sof;
        logic    sol;
        rgb565_t rgb;
    } pixel_entry_t;

    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [11:0] paddr;
        logic [31:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apb_rsp_t;

endpackage

// ==== hdl/sync_filter.sv ====
`timescale 1ns/1ns

module sync_filter #(
    parameter int HISTORY = video_capture_pkg::def_history
) (
    input  logic hw_pixel_clk,
    input  logic rst,
    input  logic sync_in,
    output logic sync_event
);

    logic [HISTORY-1:0] history;    // Newest sample in bit 0
    logic               state;      // Filtered sync level
    logic               all_ones;
    logic               all_zeros;

    assign all_ones  = &history;
    assign all_zeros = ~|history;

    // Rising edge of the filtered level, seen one cycle before state flips
    assign sync_event = ~state & all_ones;

    always_ff @(posedge hw_pixel_clk) begin
        if (rst) begin
            history <= '0;
            state   <= 1'b0;
        end else begin
            history <= {history[HISTORY-2:0], sync_in};
            if (sync_event) begin
                state <= 1'b1;
            end else if (state && all_zeros) begin
                state <= 1'b0;  // Release only after a full run of zeros
            end
        end
    end

    // A single event per sync pulse, the state must block the next cycle
    a_single_event: assert property (
        @(posedge hw_pixel_clk) disable iff (rst)
        sync_event |=> !sync_event
    ) else $error("sync_filter: event on two consecutive cycles");

endmodule

// ==== hdl/raster_tracker.sv ====
`timescale 1ns/1ns

module raster_tracker #(
    parameter int X_RES   = video_capture_pkg::def_x_res,
    parameter int Y_RES   = video_capture_pkg::def_y_res,
    parameter int H_FRONT = video_capture_pkg::def_h_front,
    parameter int H_SYNC  = video_capture_pkg::def_h_sync,
    parameter int H_BACK  = video_capture_pkg::def_h_back,
    parameter int V_FRONT = video_capture_pkg::def_v_front,
    parameter int V_SYNC  = video_capture_pkg::def_v_sync,
    parameter int V_BACK  = video_capture_pkg::def_v_back,
    parameter int HISTORY = video_capture_pkg::def_history
) (
    input  logic                         hw_pixel_clk,
    input  logic                         rst,
    input  logic                         hsync_event,
    input  logic                         vsync_event,
    output video_capture_pkg::coord_t    pixel_x,
    output video_capture_pkg::coord_t    pixel_y,
    output logic                         active,
    output logic                         locked
);

    import video_capture_pkg::*;

    localparam int H_TOTAL  = X_RES + H_FRONT + H_SYNC + H_BACK;
    localparam int V_TOTAL  = Y_RES + V_FRONT + V_SYNC + V_BACK;
    // Where the counters must stand right after a filtered sync event
    localparam int H_TARGET = X_RES + H_FRONT + HISTORY + 1;
    localparam int V_TARGET = Y_RES + V_FRONT + 1;

    coord_t x;
    coord_t y;
    coord_t x_inc;
    coord_t y_inc;
    logic   line_end;
    logic   v_pending;      // vsync seen, realign y at the line wrap
    logic   v_due;
    logic   locked_q;

    // Small phase errors are tolerated to avoid jitter on the counters
    function automatic logic in_window(coord_t pos, int target);
        return (int'(pos) >= target - 3) && (int'(pos) <= target + 1);
    endfunction

    assign x_inc    = x + coord_t'(1);
    assign y_inc    = y + coord_t'(1);
    assign line_end = (x == coord_t'(H_TOTAL - 1));
    assign v_due    = v_pending | vsync_event;

    always_ff @(posedge hw_pixel_clk) begin
        if (rst) begin
            x         <= '0;
            y         <= '0;
            v_pending <= 1'b0;
            locked_q  <= 1'b0;
        end else begin
            if (hsync_event && !in_window(x, H_TARGET)) begin
                x <= coord_t'(H_TARGET);
            end else if (line_end) begin
                x <= '0;
            end else begin
                x <= x_inc;
            end

            if (line_end) begin
                v_pending <= 1'b0;
                if (v_due && !in_window(y, V_TARGET)) begin
                    y <= coord_t'(V_TARGET);
                end else if (y == coord_t'(V_TOTAL - 1)) begin
                    y <= '0;
                end else begin
                    y <= y_inc;
                end
            end else if (vsync_event) begin
                v_pending <= 1'b1;
            end

            if (vsync_event) locked_q <= 1'b1;  // Sticky until reset
        end
    end

    assign pixel_x = x;
    assign pixel_y = y;
    assign active  = (x < coord_t'(X_RES)) && (y < coord_t'(Y_RES));
    assign locked  = locked_q;

    // Realignment target must lie inside the line
    a_x_in_line: assert property (
        @(posedge hw_pixel_clk) disable iff (rst)
        int'(x) < H_TOTAL
    ) else $error("raster_tracker: x beyond line total");

endmodule

// ==== hdl/pixel_fifo.sv ====
`timescale 1ns/1ns

module pixel_fifo #(
    parameter int DEPTH = video_capture_pkg::def_fifo_depth
) (
    input  logic                            hw_pixel_clk,
    input  logic                            rst,
    input  logic                            wr_en,
    input  video_capture_pkg::pixel_entry_t wr_data,
    input  logic                            rd_en,
    output video_capture_pkg::pixel_entry_t rd_data,
    output logic                            empty,
    output video_capture_pkg::coord_t       level,
    output logic                            overflow_pulse
);

    import video_capture_pkg::*;

    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    pixel_entry_t mem [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             full;
    logic             do_write;
    logic             do_read;

    assign full     = (count == CNT_W'(DEPTH));
    assign empty    = (count == '0);
    assign do_write = wr_en & ~full;
    assign do_read  = rd_en & ~empty;

    // Pointer advance with wrap for any depth
    function automatic logic [PTR_W-1:0] next_ptr(logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    always_ff @(posedge hw_pixel_clk) begin
        if (do_write) mem[wr_ptr] <= wr_data;
    end

    always_ff @(posedge hw_pixel_clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_write) wr_ptr <= next_ptr(wr_ptr);
            if (do_read)  rd_ptr <= next_ptr(rd_ptr);
            case ({do_write, do_read})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Head entry is visible without a read cycle
    assign rd_data        = mem[rd_ptr];
    assign level          = coord_t'(count);
    assign overflow_pulse = wr_en & full;   // Entry dropped this cycle

    a_level_bound: assert property (
        @(posedge hw_pixel_clk) disable iff (rst)
        int'(count) <= DEPTH
    ) else $error("pixel_fifo: level above depth");

endmodule

// ==== hdl/capture_regs.sv ====
`timescale 1ns/1ns

module capture_regs (
    input  logic                            hw_pixel_clk,
    input  logic                            rst,
    input  video_capture_pkg::apb_req_t     apb_req,
    output video_capture_pkg::apb_rsp_t     apb_rsp,
    input  video_capture_pkg::rgb565_t      rgb,
    input  video_capture_pkg::coord_t       pixel_x,
    input  video_capture_pkg::coord_t       pixel_y,
    input  logic                            active,
    input  logic                            locked,
    output logic                            fifo_wr_en,
    output video_capture_pkg::pixel_entry_t fifo_wr_data,
    output logic                            fifo_rd_en,
    input  video_capture_pkg::pixel_entry_t fifo_rd_data,
    input  logic                            fifo_empty,
    input  video_capture_pkg::coord_t       fifo_level,
    input  logic                            overflow_pulse
);

    import video_capture_pkg::*;

    logic        access;
    logic        wr_access;
    logic        rd_access;
    logic        addr_ok;
    logic [31:0] rdata;
    logic        enable;
    logic        overflow;        // Sticky, cleared by software
    logic        armed;
    logic [31:0] frame_count;
    logic        frame_start;
    logic        capture;

    assign access    = apb_req.psel & apb_req.penable;
    assign wr_access = access & apb_req.pwrite;
    assign rd_access = access & ~apb_req.pwrite;

    // Capture gate only changes at (0,0) so frames stay whole
    assign frame_start = active && (pixel_x == '0) && (pixel_y == '0);
    assign capture     = active && (frame_start ? (enable && locked) : armed);

    assign fifo_wr_en   = capture;
    assign fifo_wr_data = '{sof: frame_start, sol: (pixel_x == '0), rgb: rgb};
    assign fifo_rd_en   = rd_access && (apb_req.paddr == reg_pixel) && !fifo_empty;

    always_ff @(posedge hw_pixel_clk) begin
        if (rst) begin
            enable      <= 1'b0;
            overflow    <= 1'b0;
            armed       <= 1'b0;
            frame_count <= '0;
        end else begin
            if (wr_access && apb_req.paddr == reg_ctrl) begin
                enable <= apb_req.pwdata[0];
            end
            // A new drop wins over a clear in the same cycle
            if (overflow_pulse) begin
                overflow <= 1'b1;
            end else if (wr_access && apb_req.paddr == reg_status && apb_req.pwdata[17]) begin
                overflow <= 1'b0;
            end
            if (frame_start) armed <= enable && locked;
            if (capture && frame_start) frame_count <= frame_count + 1'b1;
        end
    end

    // Read mux and address decode
    always_comb begin
        rdata   = '0;
        addr_ok = 1'b1;
        case (apb_req.paddr)
            reg_ctrl:   rdata = {31'b0, enable};
            reg_status: rdata = {14'b0, overflow, locked, 5'b0, fifo_level};
            reg_pixel:  rdata = {fifo_empty, 13'b0, fifo_rd_data};
            reg_frames: rdata = frame_count;
            default:    addr_ok = 1'b0;
        endcase
    end

    always_comb begin
        apb_rsp.prdata  = rdata;
        apb_rsp.pready  = 1'b1;     // No wait states
        apb_rsp.pslverr = access & ~addr_ok;
    end

    // Error only in an access phase that follows its setup phase
    a_slverr_phase: assert property (
        @(posedge hw_pixel_clk) disable iff (rst)
        apb_rsp.pslverr |-> access && $past(apb_req.psel && !apb_req.penable)
    ) else $error("capture_regs: pslverr outside access phase");

endmodule

// ==== hdl/video_capture_top.sv ====
`timescale 1ns/1ns

module video_capture_top #(
    parameter int X_RES      = video_capture_pkg::def_x_res,
    parameter int Y_RES      = video_capture_pkg::def_y_res,
    parameter int H_FRONT    = video_capture_pkg::def_h_front,
    parameter int H_SYNC     = video_capture_pkg::def_h_sync,
    parameter int H_BACK     = video_capture_pkg::def_h_back,
    parameter int V_FRONT    = video_capture_pkg::def_v_front,
    parameter int V_SYNC     = video_capture_pkg::def_v_sync,
    parameter int V_BACK     = video_capture_pkg::def_v_back,
    parameter int HISTORY    = video_capture_pkg::def_history,
    parameter int FIFO_DEPTH = video_capture_pkg::def_fifo_depth
) (
    input  logic                        hw_pixel_clk,
    input  logic                        rst,
    input  video_capture_pkg::rgb565_t  hw_rgb_in,
    input  logic                        hw_hsync_in,
    input  logic                        hw_vsync_in,
    input  video_capture_pkg::apb_req_t apb_req,
    output video_capture_pkg::apb_rsp_t apb_rsp
);

    import video_capture_pkg::*;

    logic         hsync_event;
    logic         vsync_event;
    coord_t       pixel_x;
    coord_t       pixel_y;
    logic         active;
    logic         locked;
    logic         fifo_wr_en;
    pixel_entry_t fifo_wr_data;
    logic         fifo_rd_en;
    pixel_entry_t fifo_rd_data;
    logic         fifo_empty;
    coord_t       fifo_level;
    logic         overflow_pulse;

    sync_filter #(.HISTORY(HISTORY)) hsync_filter_inst (
        .hw_pixel_clk (hw_pixel_clk),
        .rst          (rst),
        .sync_in      (hw_hsync_in),
        .sync_event   (hsync_event)
    );

    sync_filter #(.HISTORY(HISTORY)) vsync_filter_inst (
        .hw_pixel_clk (hw_pixel_clk),
        .rst          (rst),
        .sync_in      (hw_vsync_in),
        .sync_event   (vsync_event)
    );

    raster_tracker #(
        .X_RES(X_RES), .Y_RES(Y_RES),
        .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
        .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK),
        .HISTORY(HISTORY)
    ) raster_tracker_inst (
        .hw_pixel_clk (hw_pixel_clk),
        .rst          (rst),
        .hsync_event  (hsync_event),
        .vsync_event  (vsync_event),
        .pixel_x      (pixel_x),
        .pixel_y      (pixel_y),
        .active       (active),
        .locked       (locked)
    );

    pixel_fifo #(.DEPTH(FIFO_DEPTH)) pixel_fifo_inst (
        .hw_pixel_clk   (hw_pixel_clk),
        .rst            (rst),
        .wr_en          (fifo_wr_en),
        .wr_data        (fifo_wr_data),
        .rd_en          (fifo_rd_en),
        .rd_data        (fifo_rd_data),
        .empty          (fifo_empty),
        .level          (fifo_level),
        .overflow_pulse (overflow_pulse)
    );

    // Pixel on hw_rgb_in belongs to the tracker position at this edge
    capture_regs capture_regs_inst (
        .hw_pixel_clk   (hw_pixel_clk),
        .rst            (rst),
        .apb_req        (apb_req),
        .apb_rsp        (apb_rsp),
        .rgb            (hw_rgb_in),
        .pixel_x        (pixel_x),
        .pixel_y        (pixel_y),
        .active         (active),
        .locked         (locked),
        .fifo_wr_en     (fifo_wr_en),
        .fifo_wr_data   (fifo_wr_data),
        .fifo_rd_en     (fifo_rd_en),
        .fifo_rd_data   (fifo_rd_data),
        .fifo_empty     (fifo_empty),
        .fifo_level     (fifo_level),
        .overflow_pulse (overflow_pulse)
    );

endmodule

// ==== verif/tb_clock_gen.sv ====
`timescale 1ns/1ns

module tb_clock_gen #(
    parameter int PERIOD       = 40,
    parameter int RESET_CYCLES = 3,
    parameter int DRIVE_DELAY  = 2
) (
    output logic hw_pixel_clk,
    output logic rst
);

    initial begin
        hw_pixel_clk = 1'b0;
        forever #(PERIOD / 2) hw_pixel_clk = ~hw_pixel_clk;
    end

    // Release lands just after an edge, like all other stimulus
    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge hw_pixel_clk);
        #DRIVE_DELAY;
        rst = 1'b0;
    end

endmodule

// ==== verif/video_capture_tb.sv ====
`timescale 1ns/1ns

module video_capture_tb;

    import video_capture_pkg::*;

    localparam int X_RES        = 8;
    localparam int Y_RES        = 4;
    localparam int H_FRONT      = 4;
    localparam int H_SYNC       = 6;
    localparam int H_BACK       = 6;
    localparam int V_FRONT      = 1;
    localparam int V_SYNC       = 2;
    localparam int V_BACK       = 2;
    localparam int HISTORY      = 5;
    localparam int FIFO_DEPTH   = 64;   // Two whole frames
    localparam int CLK_PERIOD   = 40;
    localparam int DRIVE_DELAY  = 2;
    localparam int SEED         = 64543;
    localparam int H_TOTAL      = X_RES + H_FRONT + H_SYNC + H_BACK;
    localparam int V_TOTAL      = Y_RES + V_FRONT + V_SYNC + V_BACK;
    localparam int FRAME_PIXELS = X_RES * Y_RES;
    localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;
    localparam int MAX_FRAMES   = 32;
    localparam int PHASE_JUMP   = 8;    // Well outside the -3..+1 window
    // Lock 2, enabled frames 2, overflow 4, phase shift 2, wrap-up 1
    localparam int TEST_FRAMES  = 2 + 2 + 4 + 2 + 1;
    localparam int TIMEOUT_NS   = 2 * TEST_FRAMES * FRAME_CYCLES * CLK_PERIOD;

    logic     hw_pixel_clk;
    logic     rst;
    rgb565_t  hw_rgb_in;
    logic     hw_hsync_in;
    logic     hw_vsync_in;
    apb_req_t apb_req;
    apb_rsp_t apb_rsp;

    // Source position presented at the next edge
    int src_x        = 0;
    int src_y        = 0;
    int src_frame    = 0;
    int jump_pending = 0;
    int checks       = 0;
    int errors       = 0;

    rgb565_t     frame_px [MAX_FRAMES][FRAME_PIXELS];   // Active pixels per source frame
    logic [31:0] got_q [$];
    logic [31:0] exp_q [$];

    tb_clock_gen #(
        .PERIOD(CLK_PERIOD), .RESET_CYCLES(3), .DRIVE_DELAY(DRIVE_DELAY)
    ) tb_clock_gen_inst (
        .hw_pixel_clk (hw_pixel_clk),
        .rst          (rst)
    );

    video_capture_top #(
        .X_RES(X_RES), .Y_RES(Y_RES),
        .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
        .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK),
        .HISTORY(HISTORY), .FIFO_DEPTH(FIFO_DEPTH)
    ) video_capture_top_inst (
        .hw_pixel_clk (hw_pixel_clk),
        .rst          (rst),
        .hw_rgb_in    (hw_rgb_in),
        .hw_hsync_in  (hw_hsync_in),
        .hw_vsync_in  (hw_vsync_in),
        .apb_req      (apb_req),
        .apb_rsp      (apb_rsp)
    );

    // prdata layout of a reg_pixel pop that finds data
    function automatic logic [31:0] expected_word(rgb565_t px, int x, int y);
        logic [31:0] word;
        word = '0;
        word[17] = (x == 0) && (y == 0);
        word[16] = (x == 0);
        word[15:0] = px;
        return word;
    endfunction

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("Fail at %0t ns: %s read 0x%08h, expected 0x%08h", $time, name, got, exp);
        end
    endtask

    // Caller stands just after an edge, returns just after the access edge
    task automatic bus_transfer(input logic wr, input logic [11:0] addr,
                                input logic [31:0] wdata,
                                output logic [31:0] rdata, output logic err);
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = wr;
        apb_req.paddr   = addr;
        apb_req.pwdata  = wdata;
        @(posedge hw_pixel_clk);
        #DRIVE_DELAY;
        apb_req.penable = 1'b1;
        #(CLK_PERIOD / 2);          // Mid access cycle
        rdata = apb_rsp.prdata;
        err   = apb_rsp.pslverr;
        compare_value("pready", 32'(apb_rsp.pready), 32'd1);
        @(posedge hw_pixel_clk);
        #DRIVE_DELAY;
        apb_req.psel    = 1'b0;
        apb_req.penable = 1'b0;
    endtask

    task automatic read_reg(input logic [11:0] addr, output logic [31:0] data,
                            output logic err);
        bus_transfer(1'b0, addr, 32'd0, data, err);
    endtask

    task automatic write_reg(input logic [11:0] addr, input logic [31:0] data);
        logic [31:0] ignored_data;
        logic        ignored_err;
        bus_transfer(1'b1, addr, data, ignored_data, ignored_err);
    endtask

    // Returns just after the edge that shows the first blanking line
    task automatic wait_vblank(output int frame);
        do begin
            @(posedge hw_pixel_clk);
        end while (!(src_x == 0 && src_y == Y_RES));
        frame = src_frame;
        #DRIVE_DELAY;
    endtask

    task automatic pop_frame(input int frame);
        logic [31:0] word;
        logic        err;
        for (int i = 0; i < FRAME_PIXELS; i++) begin
            read_reg(reg_pixel, word, err);
            got_q.push_back(word);
            exp_q.push_back(expected_word(frame_px[frame % MAX_FRAMES][i],
                                          i % X_RES, i / X_RES));
        end
    endtask

    // Video source, one raster position per clock
    initial begin : video_source
        rgb565_t px;
        void'($urandom(SEED));
        hw_rgb_in   = '0;
        hw_hsync_in = 1'b0;
        hw_vsync_in = 1'b0;
        @(negedge rst);
        forever begin
            hw_hsync_in = (src_x >= X_RES + H_FRONT) && (src_x < X_RES + H_FRONT + H_SYNC);
            hw_vsync_in = (src_y >= Y_RES + V_FRONT) && (src_y < Y_RES + V_FRONT + V_SYNC);
            if (src_x < X_RES && src_y < Y_RES) begin
                px = rgb565_t'(16'($urandom));
                frame_px[src_frame % MAX_FRAMES][src_y * X_RES + src_x] = px;
                hw_rgb_in = px;
            end else begin
                hw_rgb_in = '0;
            end
            @(posedge hw_pixel_clk);
            #DRIVE_DELAY;
            src_x = src_x + 1 + jump_pending;   // Phase shift skips positions
            jump_pending = 0;
            if (src_x >= H_TOTAL) begin
                src_x = 0;
                src_y = src_y + 1;
            end
            if (src_y == V_TOTAL) begin
                src_y = 0;
                src_frame = src_frame + 1;
            end
        end
    end

    initial begin : pop_checker
        logic [31:0] got;
        logic [31:0] exp;
        forever begin
            @(posedge hw_pixel_clk);
            while (got_q.size() > 0) begin
                got = got_q.pop_front();
                exp = exp_q.pop_front();
                compare_value("prdata", got, exp);
            end
        end
    end

    initial begin : watchdog
        #(TIMEOUT_NS);
        $display("Timeout: the test sequence did not finish within %0d ns", TIMEOUT_NS);
        $display("Checks: %0d, errors: %0d", checks, errors);
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin : test_sequence
        logic [31:0] word;
        logic        err;
        int          frame;
        int          frames_armed;
        apb_req = '0;
        frames_armed = 0;
        @(negedge rst);

        // Reset values
        read_reg(reg_ctrl, word, err);
        compare_value("ctrl", word, 32'd0);
        compare_value("pslverr", 32'(err), 32'd0);
        read_reg(reg_status, word, err);
        compare_value("status.level", 32'(word[10:0]), 32'd0);
        compare_value("status.overflow", 32'(word[17]), 32'd0);
        read_reg(reg_frames, word, err);
        compare_value("frames", word, 32'd0);
        read_reg(reg_pixel, word, err);
        compare_value("pixel.empty", 32'(word[31]), 32'd1);

        // First vsync falls in frame 0, so lock is in place by frame 1
        wait_vblank(frame);
        wait_vblank(frame);
        read_reg(reg_status, word, err);
        compare_value("status.locked", 32'(word[16]), 32'd1);
        write_reg(reg_ctrl, 32'd1);
        read_reg(reg_ctrl, word, err);
        compare_value("ctrl", word, 32'd1);
        repeat (2) begin
            wait_vblank(frame);
            pop_frame(frame);
            frames_armed++;
        end
        read_reg(reg_frames, word, err);
        compare_value("frames", word, 32'(frames_armed));

        // Undrained: two frames fill the FIFO, the third is dropped
        repeat (3) begin
            wait_vblank(frame);
            frames_armed++;
        end
        write_reg(reg_ctrl, 32'd0);
        read_reg(reg_ctrl, word, err);
        compare_value("ctrl", word, 32'd0);
        read_reg(reg_status, word, err);
        compare_value("status.level", 32'(word[10:0]), 32'(FIFO_DEPTH));
        compare_value("status.overflow", 32'(word[17]), 32'd1);
        pop_frame(frame - 2);
        pop_frame(frame - 1);
        read_reg(reg_pixel, word, err);
        compare_value("pixel.empty", 32'(word[31]), 32'd1);
        write_reg(reg_status, 32'h0002_0000);
        read_reg(reg_status, word, err);
        compare_value("status.overflow", 32'(word[17]), 32'd0);
        compare_value("status.level", 32'(word[10:0]), 32'd0);
        read_reg(reg_frames, word, err);
        compare_value("frames", word, 32'(frames_armed));

        // Hsync phase jump in blanking, next frame must still match
        wait_vblank(frame);
        #(CLK_PERIOD / 2);
        jump_pending = PHASE_JUMP;          // Taken by the source at its next step
        @(posedge hw_pixel_clk);
        #DRIVE_DELAY;
        write_reg(reg_ctrl, 32'd1);
        wait_vblank(frame);
        frames_armed++;
        pop_frame(frame);
        read_reg(reg_frames, word, err);
        compare_value("frames", word, 32'(frames_armed));

        // Unmapped addresses
        read_reg(12'h010, word, err);
        compare_value("pslverr", 32'(err), 32'd1);
        bus_transfer(1'b1, 12'h020, 32'hFFFF_FFFF, word, err);
        compare_value("pslverr", 32'(err), 32'd1);
        write_reg(reg_ctrl, 32'd0);
        read_reg(reg_ctrl, word, err);
        compare_value("ctrl", word, 32'd0);

        repeat (2) @(posedge hw_pixel_clk);    // Let the checker drain
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// ==== video_capture_top.f ====
hdl/video_capture_pkg.sv
hdl/sync_filter.sv
hdl/raster_tracker.sv
hdl/pixel_fifo.sv
hdl/capture_regs.sv
hdl/video_capture_top.sv
verif/tb_clock_gen.sv
verif/video_capture_tb.sv

// ==== Makefile ====
# Verilator flow for the video capture subsystem

VERILATOR  ?= verilator
FILELIST   ?= video_capture_top.f
TB_TOP     ?= video_capture_tb
RTL_TOP    ?= video_capture_top
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
PASS_MSG   ?= PASS: all tests
LINT_FLAGS ?= --lint-only -Wall --timing
SIM_FLAGS  ?= --binary --timing --assert -Wno-fatal

SOURCES := $(wildcard hdl/*.sv verif/*.sv)
SIM_BIN := $(BUILD_DIR)/V$(TB_TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TB_TOP) --Mdir $(BUILD_DIR)

# The log decides, since the simulator exit code is not reliable through tee
sim: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
